/* build.f */
logic/panelPkg.sv
logic/memPkg.sv
logic/memReqIf.sv
logic/entryRegs.sv
logic/cmdSequencer.sv
logic/inOutControl.sv
verif/reqChecker.sv
verif/inOutControlTb.sv

/* run.sh */
#!/bin/sh
# compile and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wall -Wno-fatal \
    --top-module inOutControlTb \
    -f build.f \
    -o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi

/* verif/inOutControlTb.sv */
module inOutControlTb import panelPkg::*, memPkg::*; ();

    localparam int NumRows = 6;

    // table row of command, address, data, stall and abort flag
    typedef struct packed {
        cmdSel_t   cmd;
        memAddr_t  addr;
        memData_t  data;
        logic [1:0] stall;
        logic      abort;
    } rowRec_t;

    rowRec_t rows [NumRows];

    logic        sw;
    logic        rstN;
    buttonCode_t button;
    logic [DigitCount-1:0] digitSw;
    logic        memValid;
    logic        memReady;
    memOp_t      memOp;
    memAddr_t    memAddr;
    memData_t    memWrData;
    logic        memRdValid;
    memData_t    memRdData;
    dispWord_t   dispData;

    // checker side
    logic     rowStart;
    logic     rowEnd;
    int       rowIdx;
    cmdSel_t  expCmd;
    logic     expNone;
    memAddr_t expAddr;
    memData_t expData;
    logic     dispChk;
    logic     dispHalf;
    memData_t dispExp;
    int       testsRun;
    int       testsFailed;
    int       errCount;

    // responder state
    int       stallCnt;
    logic [1:0] curStall;
    int       xferTotal;
    int       rdCount;
    int       rdWait;
    memAddr_t rdAddr;
    cmdSel_t  curCmd;
    int       seedVal;

    inOutControl dut_i (
        .sw(sw), .rstN(rstN), .button(button), .digitSw(digitSw),
        .memValid(memValid), .memReady(memReady), .memOp(memOp),
        .memAddr(memAddr), .memWrData(memWrData), .memRdValid(memRdValid),
        .memRdData(memRdData), .dispData(dispData)
    );

    reqChecker chk_i (
        .sw(sw), .rstN(rstN), .memValid(memValid), .memReady(memReady),
        .memOp(memOp), .memAddr(memAddr), .memWrData(memWrData), .dispData(dispData),
        .rowStart(rowStart), .rowEnd(rowEnd), .rowIdx(rowIdx), .expCmd(expCmd),
        .expNone(expNone), .expAddr(expAddr), .expData(expData), .dispChk(dispChk),
        .dispHalf(dispHalf), .dispExp(dispExp), .testsRun(testsRun),
        .testsFailed(testsFailed), .errCount(errCount)
    );

    always #4 sw = ~sw;

    // memory responder with random stall and read return 2 to 5 cycles later
    always @(posedge sw) begin
        if (memValid && memReady) begin
            memReady <= 1'b0;
            stallCnt <= (curStall != 0) ? curStall : $urandom % 4;
            xferTotal <= xferTotal + 1;
            if (memOp == OpRead) begin
                rdAddr <= memAddr;
                rdWait <= 2 + $urandom % 4;
            end
        end else if (memValid && !memReady) begin
            if (stallCnt == 0) memReady <= 1'b1;
            else stallCnt <= stallCnt - 1;
        end else if (rowStart) begin
            // stall for the first request of the new row
            stallCnt <= (curStall != 0) ? curStall : $urandom % 4;
        end
        memRdValid <= 1'b0;
        if (rdWait > 0) begin
            rdWait <= rdWait - 1;
            if (rdWait == 1) begin
                memRdValid <= 1'b1;
                memRdData  <= rdAddr[15:0] ^ 16'hA5A5;
                rdCount    <= rdCount + 1;
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) @(posedge sw);
    endtask

    task automatic pressButton(input buttonCode_t code);
        @(posedge sw) button <= code;
        @(posedge sw) button <= BtnNone;
        @(posedge sw);
    endtask

    task automatic pulseDigit(input int i, input int n);
        repeat (n) begin
            @(posedge sw) digitSw[i] <= 1'b1;
            @(posedge sw) digitSw[i] <= 1'b0;
        end
    endtask

    // nibble value v takes v pulses
    task automatic enterField16(input logic [15:0] v);
        for (int i = 0; i < DigitCount; i++) pulseDigit(i, v[i*4 +: 4]);
        idle(2);
    endtask

    task automatic enterHigh(input memAddr_t a);
        pulseDigit(0, a[19:16]);
        pulseDigit(1, a[23:20]);
        if (a[24]) pulseDigit(2, 1);
        idle(2);
    endtask

    task automatic checkDisp(input logic upper, input logic [15:0] v);
        @(posedge sw) begin
            dispChk  <= 1'b1;
            dispHalf <= upper;
            dispExp  <= v;
        end
        @(posedge sw) dispChk <= 1'b0;
    endtask

    // rotate clear, write, read until the target is selected
    task automatic selectCmd(input cmdSel_t target);
        while (curCmd != target) begin
            pressButton(BtnCycle);
            curCmd = (curCmd == CmdClear) ? CmdWrite : (curCmd == CmdWrite) ? CmdRead : CmdClear;
        end
    endtask

    task automatic runRow(input int r);
        int base;
        int rdBase;
        @(posedge sw) begin
            rowIdx   <= r;
            expCmd   <= rows[r].cmd;
            expNone  <= rows[r].abort;
            expAddr  <= rows[r].addr;
            expData  <= rows[r].data;
            curStall <= rows[r].stall;
            rowStart <= 1'b1;
        end
        @(posedge sw) rowStart <= 1'b0;
        selectCmd(rows[r].cmd);
        base   = xferTotal;
        rdBase = rdCount;
        pressButton(BtnExecute);
        if (rows[r].cmd == CmdClear) begin
            while (xferTotal - base < ClearLastAddr + 1) @(posedge sw);
        end else begin
            enterField16(rows[r].addr[15:0]);
            checkDisp(1'b0, rows[r].addr[15:0]);
            if (rows[r].abort) begin
                // abandoned entry must come back as zero
                pressButton(BtnReset);
                curCmd = CmdClear;
                idle(2);
                checkDisp(1'b0, 16'h0000);
            end else begin
                pressButton(BtnExecute);
                enterHigh(rows[r].addr);
                checkDisp(1'b0, {7'b0, rows[r].addr[24:16]});
                if (rows[r].cmd == CmdWrite) begin
                    pressButton(BtnExecute);
                    enterField16(rows[r].data);
                    checkDisp(1'b0, rows[r].data);
                end
                base = xferTotal;
                pressButton(BtnExecute);
                while (xferTotal == base) @(posedge sw);
                if (rows[r].cmd == CmdRead) begin
                    while (rdCount == rdBase) @(posedge sw);
                    idle(3);
                    checkDisp(1'b1, rows[r].addr[15:0] ^ 16'hA5A5);
                end
            end
        end
        idle(4);
        @(posedge sw) rowEnd <= 1'b1;
        @(posedge sw) rowEnd <= 1'b0;
        idle(2);
    endtask

    initial begin
        sw = 1'b0;
        rstN = 1'b0;
        button = BtnNone;
        digitSw = '0;
        memReady = 1'b0;
        memRdValid = 1'b0;
        memRdData = '0;
        rowStart = 1'b0;
        rowEnd = 1'b0;
        rowIdx = 0;
        expCmd = CmdClear;
        expNone = 1'b1;
        expAddr = '0;
        expData = '0;
        dispChk = 1'b0;
        dispHalf = 1'b0;
        dispExp = '0;
        stallCnt = 0;
        curStall = 0;
        xferTotal = 0;
        rdCount = 0;
        rdWait = 0;
        rdAddr = '0;
        curCmd = CmdClear;
        seedVal = $urandom(15003);
        rows[0] = '{CmdWrite, 25'h112A5C3, 16'hBEEF, 2'd2, 1'b0};
        rows[1] = '{CmdRead, 25'h112A5C3, 16'h0000, 2'd0, 1'b0};
        rows[2] = '{CmdClear, 25'h0, 16'h0000, 2'd0, 1'b0};
        rows[3] = '{CmdWrite, 25'h0034, 16'h0055, 2'd0, 1'b1};
        rows[4] = '{CmdWrite, 25'h03F012, 16'h1234, 2'd3, 1'b0};
        rows[5] = '{CmdRead, 25'h0007, 16'h0000, 2'd1, 1'b0};
        repeat (10) @(posedge sw);
        rstN <= 1'b1;
        idle(2);
        for (int r = 0; r < NumRows; r++) runRow(r);
        $display("rows %0d, failed %0d, errors %0d", testsRun, testsFailed, errCount);
        if (testsFailed == 0 && errCount == 0 && testsRun == NumRows) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // budget from the row count and the sweep length
    initial begin
        repeat (NumRows * 400 + (ClearLastAddr + 1) * 10) @(posedge sw);
        $display("timeout: the run did not finish within its cycle budget");
        $display("Test FAILED");
        $finish;
    end

endmodule

/* verif/reqChecker.sv */
module reqChecker import panelPkg::*, memPkg::*; (
    input  logic      sw,
    input  logic      rstN,
    input  logic      memValid,
    input  logic      memReady,
    input  memOp_t    memOp,
    input  memAddr_t  memAddr,
    input  memData_t  memWrData,
    input  dispWord_t dispData,
    // expected record for the current row
    input  logic      rowStart,
    input  logic      rowEnd,
    input  int        rowIdx,
    input  cmdSel_t   expCmd,
    input  logic      expNone,
    input  memAddr_t  expAddr,
    input  memData_t  expData,
    // display compare strobe
    input  logic      dispChk,
    input  logic      dispHalf,
    input  memData_t  dispExp,
    output int        testsRun,
    output int        testsFailed,
    output int        errCount
);

    int       rowErrs;
    int       xferCnt;
    memAddr_t sweepNext;

    // previous cycle request for back-pressure checks
    logic     prevValid;
    logic     prevReady;
    memOp_t   prevOp;
    memAddr_t prevAddr;
    memData_t prevData;

    task automatic fieldError(input string name, input logic [31:0] expV,
                              input logic [31:0] gotV);
        $display("ERROR t=%0t %s expected %h got %h", $time, name, expV, gotV);
        rowErrs++;
        errCount++;
    endtask

    task automatic plainError(input string what);
        $display("ERROR t=%0t %s", $time, what);
        rowErrs++;
        errCount++;
    endtask

    initial begin
        testsRun    = 0;
        testsFailed = 0;
        errCount    = 0;
        rowErrs     = 0;
        xferCnt     = 0;
        sweepNext   = '0;
        prevValid   = 1'b0;
        prevReady   = 1'b0;
    end

    always @(posedge sw) begin
        int expCnt;
        if (rstN) begin
            // stalled request must hold still
            if (prevValid && !prevReady) begin
                if (!memValid) plainError("memValid dropped before the transfer");
                if (memOp != prevOp) fieldError("memOp (stall)", prevOp, memOp);
                if (memAddr != prevAddr) fieldError("memAddr (stall)", prevAddr, memAddr);
                if (memWrData != prevData) fieldError("memWrData (stall)", prevData, memWrData);
            end
            if (memValid && memReady) begin
                xferCnt++;
                if (expNone) begin
                    plainError("transfer seen where none was expected");
                end else if (expCmd == CmdClear) begin
                    // sweep goes up by one address per transfer
                    if (memOp != OpWrite) fieldError("memOp", OpWrite, memOp);
                    if (memAddr != sweepNext) fieldError("memAddr", sweepNext, memAddr);
                    if (memWrData != '0) fieldError("memWrData", 0, memWrData);
                    sweepNext = sweepNext + 1'b1;
                end else if (expCmd == CmdRead) begin
                    if (memOp != OpRead) fieldError("memOp", OpRead, memOp);
                    if (memAddr != expAddr) fieldError("memAddr", expAddr, memAddr);
                end else begin
                    if (memOp != OpWrite) fieldError("memOp", OpWrite, memOp);
                    if (memAddr != expAddr) fieldError("memAddr", expAddr, memAddr);
                    if (memWrData != expData) fieldError("memWrData", expData, memWrData);
                end
            end
            if (dispChk) begin
                if (dispHalf && dispData[31:16] != dispExp) begin
                    fieldError("dispData[31:16]", dispExp, dispData[31:16]);
                end else if (!dispHalf && dispData[15:0] != dispExp) begin
                    fieldError("dispData[15:0]", dispExp, dispData[15:0]);
                end
            end
            if (rowStart) begin
                rowErrs   = 0;
                xferCnt   = 0;
                sweepNext = '0;
            end
            if (rowEnd) begin
                if (expNone) expCnt = 0;
                else if (expCmd == CmdClear) expCnt = ClearLastAddr + 1;
                else expCnt = 1;
                if (xferCnt != expCnt) begin
                    plainError($sformatf("row %0d made %0d transfers, wanted %0d",
                        rowIdx, xferCnt, expCnt));
                end
                testsRun++;
                if (rowErrs != 0) testsFailed++;
                $display("row %0d %s: %s", rowIdx, expNone ? "abort" : expCmd.name(),
                    (rowErrs == 0) ? "pass" : "fail");
            end
        end
        prevValid = memValid;
        prevReady = memReady;
        prevOp    = memOp;
        prevAddr  = memAddr;
        prevData  = memWrData;
    end

endmodule

/* logic/inOutControl.sv */
module inOutControl import panelPkg::*, memPkg::*; (
    input  logic                  sw,
    input  logic                  rstN,
    input  buttonCode_t           button,
    input  logic [DigitCount-1:0] digitSw,
    output logic                  memValid,
    input  logic                  memReady,
    output memOp_t                memOp,
    output memAddr_t              memAddr,
    output memData_t              memWrData,
    input  logic                  memRdValid,
    input  memData_t              memRdData,
    output dispWord_t             dispData
);

    // sequencer to register block
    phase_t   phase;
    logic     clearEntry;
    memAddr_t entryAddr;
    memData_t entryData;

    // request bundle toward the memory ports
    memReqIf reqBus ();

    cmdSequencer cmdSequencer_i (
        .sw         (sw),
        .rstN       (rstN),
        .button     (button),
        .phase      (phase),
        .clearEntry (clearEntry),
        .entryAddr  (entryAddr),
        .entryData  (entryData),
        .memRdValid (memRdValid),
        .req        (reqBus.master)
    );

    entryRegs entryRegs_i (
        .sw         (sw),
        .rstN       (rstN),
        .digitSw    (digitSw),
        .phase      (phase),
        .clearEntry (clearEntry),
        .memRdValid (memRdValid),
        .memRdData  (memRdData),
        .entryAddr  (entryAddr),
        .entryData  (entryData),
        .dispData   (dispData)
    );

    // memory side of the bundle onto plain ports
    assign memValid     = reqBus.valid;
    assign memOp        = reqBus.op;
    assign memAddr      = reqBus.addr;
    assign memWrData    = reqBus.wrData;
    assign reqBus.ready = memReady;

endmodule

/* logic/cmdSequencer.sv */
module cmdSequencer import panelPkg::*, memPkg::*; (
    input  logic        sw,
    input  logic        rstN,
    input  buttonCode_t button,
    output phase_t      phase,
    output logic        clearEntry,
    input  memAddr_t    entryAddr,
    input  memData_t    entryData,
    input  logic        memRdValid,
    memReqIf.master     req
);

    // button edge detect
    buttonCode_t btnPrev;
    logic        btnEdge;
    logic        rstPress;
    logic        exePress;
    logic        cyclePress;

    // sequencer state
    phase_t   phaseReg;
    cmdSel_t  cmdReg;
    logic     validReg;
    memAddr_t sweepAddr;

    // request accepted this cycle
    logic xfer;

    // acts only on the step from idle to a code so a held code acts once
    assign btnEdge    = (btnPrev == BtnNone) && (button != BtnNone);
    assign rstPress   = btnEdge && (button == BtnReset);
    assign exePress   = btnEdge && (button == BtnExecute);
    assign cyclePress = btnEdge && (button == BtnCycle);

    assign xfer = validReg && req.ready;

    // entry fields start from zero on abort and on every new command
    assign clearEntry = rstPress || (exePress && (phaseReg == PhSelect));

    always_ff @(posedge sw or negedge rstN) begin
        if (!rstN) begin
            btnPrev <= BtnNone;
        end else begin
            btnPrev <= button;
        end
    end

    always_ff @(posedge sw or negedge rstN) begin
        if (!rstN) begin
            phaseReg  <= PhSelect;
            cmdReg    <= CmdClear;
            validReg  <= 1'b0;
            sweepAddr <= '0;
        end else if (rstPress) begin
            // abort wins over everything including a pending request
            phaseReg  <= PhSelect;
            cmdReg    <= CmdClear;
            validReg  <= 1'b0;
            sweepAddr <= '0;
        end else begin
            case (phaseReg)
                PhSelect: begin
                    if (cyclePress) begin
                        // clear, write, read, clear
                        case (cmdReg)
                            CmdClear: cmdReg <= CmdWrite;
                            CmdWrite: cmdReg <= CmdRead;
                            default:  cmdReg <= CmdClear;
                        endcase
                    end else if (exePress) begin
                        if (cmdReg == CmdClear) begin
                            // sweep starts at address 0 right away
                            phaseReg  <= PhClear;
                            sweepAddr <= '0;
                            validReg  <= 1'b1;
                        end else begin
                            phaseReg <= PhAddrLo;
                        end
                    end
                end
                PhAddrLo: begin
                    if (exePress) begin
                        phaseReg <= PhAddrHi;
                    end
                end
                PhAddrHi: begin
                    if (exePress) begin
                        if (cmdReg == CmdRead) begin
                            // read needs no data phase
                            phaseReg <= PhIssue;
                            validReg <= 1'b1;
                        end else begin
                            phaseReg <= PhData;
                        end
                    end
                end
                PhData: begin
                    if (exePress) begin
                        phaseReg <= PhIssue;
                        validReg <= 1'b1;
                    end
                end
                PhIssue: begin
                    // hold until accepted
                    if (xfer) begin
                        validReg <= 1'b0;
                        if (cmdReg == CmdRead) begin
                            phaseReg <= PhWaitRead;
                        end else begin
                            phaseReg <= PhSelect;
                        end
                    end
                end
                PhWaitRead: begin
                    // read word is captured by the register block
                    if (memRdValid) begin
                        phaseReg <= PhSelect;
                    end
                end
                PhClear: begin
                    // one write per accepted cycle while a stall keeps the address
                    if (xfer) begin
                        if (sweepAddr == memAddr_t'(ClearLastAddr)) begin
                            validReg  <= 1'b0;
                            sweepAddr <= '0;
                            phaseReg  <= PhSelect;
                        end else begin
                            sweepAddr <= sweepAddr + 1'b1;
                        end
                    end
                end
                default: begin
                    phaseReg <= PhSelect;
                    validReg <= 1'b0;
                end
            endcase
        end
    end

    assign phase = phaseReg;

    // request drive with zero data during the sweep
    assign req.valid  = validReg;
    assign req.op     = (cmdReg == CmdRead) ? OpRead : OpWrite;
    assign req.addr   = (phaseReg == PhClear) ? sweepAddr : entryAddr;
    assign req.wrData = (phaseReg == PhClear) ? '0 : entryData;

endmodule

/* logic/entryRegs.sv */
module entryRegs import panelPkg::*, memPkg::*; (
    input  logic                  sw,
    input  logic                  rstN,
    input  logic [DigitCount-1:0] digitSw,
    input  phase_t                phase,
    input  logic                  clearEntry,
    input  logic                  memRdValid,
    input  memData_t              memRdData,
    output memAddr_t              entryAddr,
    output memData_t              entryData,
    output dispWord_t             dispData
);

    // previous switch sample for edge detect
    logic [DigitCount-1:0] swPrev;
    logic [DigitCount-1:0] swRise;

    // entered fields and last returned read word
    memAddr_t addrReg;
    memData_t dataReg;
    memData_t rdDataReg;

    // field shown in the lower display half
    memData_t editView;

    // 0 to 1 transitions only
    assign swRise = digitSw & ~swPrev;

    always_ff @(posedge sw or negedge rstN) begin
        if (!rstN) begin
            swPrev <= '0;
        end else begin
            swPrev <= digitSw;
        end
    end

    // nibble editing in the field picked by phase
    always_ff @(posedge sw or negedge rstN) begin
        if (!rstN) begin
            addrReg <= '0;
            dataReg <= '0;
        end else if (clearEntry) begin
            addrReg <= '0;
            dataReg <= '0;
        end else begin
            case (phase)
                PhAddrLo: begin
                    // one switch per low address nibble and F wraps to 0
                    for (int i = 0; i < DigitCount; i++) begin
                        if (swRise[i]) begin
                            addrReg[i*NibbleBits +: NibbleBits] <=
                                addrReg[i*NibbleBits +: NibbleBits] + 1'b1;
                        end
                    end
                end
                PhAddrHi: begin
                    // bits 19:16
                    if (swRise[0]) begin
                        addrReg[AddrLoBits +: NibbleBits] <=
                            addrReg[AddrLoBits +: NibbleBits] + 1'b1;
                    end
                    // bits 23:20
                    if (swRise[1]) begin
                        addrReg[AddrLoBits+NibbleBits +: NibbleBits] <=
                            addrReg[AddrLoBits+NibbleBits +: NibbleBits] + 1'b1;
                    end
                    // top address bit is a single toggle
                    if (swRise[2]) begin
                        addrReg[AddrLoBits+2*NibbleBits] <= ~addrReg[AddrLoBits+2*NibbleBits];
                    end
                    // switch 3 has no bits left here
                end
                PhData: begin
                    for (int i = 0; i < DigitCount; i++) begin
                        if (swRise[i]) begin
                            dataReg[i*NibbleBits +: NibbleBits] <=
                                dataReg[i*NibbleBits +: NibbleBits] + 1'b1;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // capture read return on the strobe
    always_ff @(posedge sw or negedge rstN) begin
        if (!rstN) begin
            rdDataReg <= '0;
        end else if (memRdValid) begin
            rdDataReg <= memRdData;
        end
    end

    // lower display half follows the phase
    always_comb begin
        case (phase)
            PhAddrHi: editView = memData_t'(addrReg[AddrLoBits +: AddrHiBits]);
            PhData:   editView = dataReg;
            default:  editView = addrReg[AddrLoBits-1:0];
        endcase
    end

    assign entryAddr = addrReg;
    assign entryData = dataReg;
    assign dispData  = {rdDataReg, editView};

endmodule

/* logic/memReqIf.sv */
interface memReqIf import memPkg::*; ();

    // request handshake
    logic     valid;
    logic     ready;

    // payload held stable while valid and not ready
    memOp_t   op;
    memAddr_t addr;
    memData_t wrData;

    // request source side
    modport master (
        output valid,
        output op,
        output addr,
        output wrData,
        input  ready
    );

    // memory side
    modport slave (
        input  valid,
        input  op,
        input  addr,
        input  wrData,
        output ready
    );

endinterface

/* logic/memPkg.sv */
package memPkg;

    // address split as entered on the panel
    localparam int AddrLoBits = 16;
    localparam int AddrHiBits = 9;

    // memory word width
    localparam int DataBits = 16;

    // last address written by a clear sweep
    localparam int ClearLastAddr = 63;

    typedef logic [AddrLoBits+AddrHiBits-1:0] memAddr_t;
    typedef logic [DataBits-1:0]              memData_t;

    // read data in the upper half and the field under edit in the lower half
    typedef logic [2*DataBits-1:0] dispWord_t;

    // operation carried with each request
    typedef enum logic {
        OpWrite,
        OpRead
    } memOp_t;

endpackage

/* logic/panelPkg.sv */
package panelPkg;

    // width of one hex digit on the panel
    localparam int NibbleBits = 4;

    // one switch per hex digit of a 16-bit field
    localparam int DigitCount = 4;

    // debounced button code
    typedef logic [1:0] buttonCode_t;

    // no button pressed
    localparam buttonCode_t BtnNone    = 2'b00;
    // abort and go back to command selection
    localparam buttonCode_t BtnReset   = 2'b11;
    // step to next entry phase or issue
    localparam buttonCode_t BtnExecute = 2'b10;
    // rotate the selected command
    localparam buttonCode_t BtnCycle   = 2'b01;

    // command chosen at the select level
    typedef enum logic [1:0] {
        CmdClear,
        CmdWrite,
        CmdRead
    } cmdSel_t;

    // entry phase, shared by sequencer and register block
    typedef enum logic [2:0] {
        PhSelect,
        PhAddrLo,
        PhAddrHi,
        PhData,
        PhIssue,
        PhWaitRead,
        PhClear
    } phase_t;

endpackage
